// File: dv/tcdm_group_tb.sv
/* Testbench of the TCDM group: clock, reset, directed and random traffic,
   byte reference memory and response assertions */

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_group_tb;
  import tcdm_pkg::*;

  localparam int NUM_TAGS = 1 << `TCDM_TAG_WIDTH;
  localparam int MEM_BYTES = 1 << `TCDM_ADDR_WIDTH;
  localparam int TIMEOUT = 500;

  logic clk_i;
  logic rst_n_i;
  logic req_valid_i;
  logic req_ready_o;
  tcdm_addr_u req_addr_i;
  logic req_wen_i;
  tcdm_data_t req_wdata_i;
  tcdm_strb_t req_be_i;
  tcdm_tag_t req_tag_i;
  logic resp_valid_o;
  logic resp_ready_i;
  tcdm_data_t resp_rdata_o;
  tcdm_tag_t resp_tag_o;

  // Reference memory and outstanding tag table
  logic [7:0] ref_mem [MEM_BYTES];
  tcdm_data_t exp_rdata [NUM_TAGS];
  logic [NUM_TAGS-1:0] pending;
  tcdm_data_t exp_now;
  logic pend_now;

  integer seed;
  logic rand_ready;
  int err_count;
  int tests_run;
  int tests_failed;

  tcdm_group tcdm_group_inst (
    .clk_i (clk_i),
    .rst_n_i (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i (req_addr_i),
    .req_wen_i (req_wen_i),
    .req_wdata_i (req_wdata_i),
    .req_be_i (req_be_i),
    .req_tag_i (req_tag_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .resp_tag_o (resp_tag_o)
  );

  always #5 clk_i = ~clk_i;

  // Random back-pressure on the response port
  always @(posedge clk_i) begin
    if (rand_ready) begin
      resp_ready_i <= (($random(seed) & 32'd1) != 0);
    end else begin
      resp_ready_i <= 1'b1;
    end
  end

  // Requests are executed in acceptance order, so expectations are taken here
  always @(posedge clk_i) begin : track_traffic
    logic [`TCDM_ADDR_WIDTH-1:0] base;
    logic [NUM_TAGS-1:0] pend_next;
    pend_next = pending;
    if (!rst_n_i) begin
      pend_next = '0;
    end else begin
      if (resp_valid_o && resp_ready_i) begin
        pend_next[resp_tag_o] = 1'b0;
      end
      if (req_valid_i && req_ready_o) begin
        base = {req_addr_i.raw[`TCDM_ADDR_WIDTH-1:2], 2'b00};
        pend_next[req_tag_i] = 1'b1;
        if (req_wen_i) begin
          exp_rdata[req_tag_i] <= '0;
          for (int i = 0; i < 4; i++) begin
            if (req_be_i[i]) begin
              ref_mem[base + i] = req_wdata_i[8*i +: 8];
            end
          end
        end else begin
          exp_rdata[req_tag_i] <= {ref_mem[base + 3], ref_mem[base + 2],
                                   ref_mem[base + 1], ref_mem[base]};
        end
      end
    end
    pending <= pend_next;
  end

  assign exp_now = exp_rdata[resp_tag_o];
  assign pend_now = pending[resp_tag_o];

  resp_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_valid_o && resp_ready_i |-> pend_now && resp_rdata_o == exp_now)
    else begin
      err_count = err_count + 1;
      $display("ERROR %0t: tag %0d returned %h, expected %h, outstanding %b", $time,
               $sampled(resp_tag_o), $sampled(resp_rdata_o), $sampled(exp_now),
               $sampled(pend_now));
    end

  resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_valid_o && !resp_ready_i |=>
        resp_valid_o && $stable(resp_rdata_o) && $stable(resp_tag_o))
    else begin
      err_count = err_count + 1;
      $display("ERROR %0t: response changed while resp_ready_i was low", $time);
    end

  // Called on a rising edge, returns on the edge of the transfer
  task automatic send_req(input logic [`TCDM_ADDR_WIDTH-1:0] addr, input logic wen,
                          input tcdm_data_t wdata, input tcdm_strb_t be, input tcdm_tag_t tag);
    int waited;
    waited = 0;
    while (pending[tag] && waited < TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (pending[tag]) begin
      err_count = err_count + 1;
      $display("Timeout: tag %0d was never answered, so it cannot be reused", tag);
    end
    req_valid_i <= 1'b1;
    req_addr_i.raw <= addr;
    req_wen_i <= wen;
    req_wdata_i <= wdata;
    req_be_i <= be;
    req_tag_i <= tag;
    waited = 0;
    @(negedge clk_i);
    while (!req_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!req_ready_o) begin
      err_count = err_count + 1;
      $display("Timeout: request with tag %0d was never accepted", tag);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (pending != '0 && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (pending != '0) begin
      err_count = err_count + 1;
      for (int t = 0; t < NUM_TAGS; t++) begin
        if (pending[t]) begin
          $display("Timeout: response for tag %0d never arrived", t);
        end
      end
    end
    @(posedge clk_i);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
    end
    $display("test %0d %s: %0d errors", tests_run, name, err_count - errs_before);
  endtask

  initial begin
    int errs;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i = '0;
    req_wen_i = 1'b0;
    req_wdata_i = '0;
    req_be_i = '0;
    req_tag_i = '0;
    resp_ready_i = 1'b1;
    rand_ready = 1'b0;
    pending = '0;
    seed = 90;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    errs = err_count;
    @(negedge clk_i);
    reset_state: assert (!resp_valid_o && req_ready_o)
      else begin
        err_count = err_count + 1;
        $display("ERROR %0t: idle state after reset is wrong", $time);
      end
    @(posedge clk_i);
    report_test("reset state", errs);

    errs = err_count;
    send_req(10'h120, 1'b1, 32'hcafe_0123, 4'hf, 4'd1);
    send_req(10'h120, 1'b0, '0, 4'hf, 4'd2);
    wait_idle();
    report_test("write then read", errs);

    // Known word, then a write of bytes 0 and 2 only
    errs = err_count;
    send_req(10'h2c8, 1'b1, 32'h1122_3344, 4'hf, 4'd3);
    send_req(10'h2c8, 1'b1, 32'haabb_ccdd, 4'b0101, 4'd4);
    send_req(10'h2c8, 1'b0, '0, 4'hf, 4'd5);
    wait_idle();
    report_test("partial byte enables", errs);

    errs = err_count;
    for (int i = 0; i < 16; i++) begin
      send_req(10'(4 * i), 1'b1, $random(seed), 4'hf, 4'(i));
    end
    wait_idle();
    for (int i = 0; i < 16; i++) begin
      send_req(10'(4 * i), 1'b0, '0, 4'hf, 4'(15 - i));
    end
    wait_idle();
    report_test("all banks back to back", errs);

    errs = err_count;
    rand_ready = 1'b1;
    for (int n = 0; n < 48; n++) begin
      send_req(10'(4 * ($random(seed) & 15)), 1'($random(seed)), $random(seed),
               4'($random(seed)), 4'(n % NUM_TAGS));
    end
    wait_idle();
    rand_ready = 1'b0;
    report_test("random back-pressure", errs);

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/tcdm_pkg.sv
src/tcdm_bank_if.sv
src/tcdm_req_decoder.sv
src/tcdm_bank.sv
src/tcdm_resp_arbiter.sv
src/tcdm_group.sv
dv/tcdm_group_tb.sv

// File: src/tcdm_bank.sv
/* One TCDM bank: word memory with byte-enable writes and a
   two-entry tagged response queue */

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_bank (
  input logic clk_i,
  input logic rst_n_i,
  tcdm_bank_if.bank bus_io
);
  import tcdm_pkg::*;

  tcdm_data_t mem_q [`TCDM_BANK_DEPTH];

  // Response queue storage
  tcdm_data_t q_rdata_q [2];
  tcdm_tag_t q_tag_q [2];
  logic wr_ptr_q;
  logic rd_ptr_q;
  logic [1:0] count_q;

  logic push;
  logic pop;

  // No room once both queue entries are taken
  assign bus_io.req_ready = (count_q != 2'd2);
  assign push = bus_io.req_valid && bus_io.req_ready;
  assign pop = bus_io.resp_valid && bus_io.resp_ready;

  assign bus_io.resp_valid = (count_q != 2'd0);
  assign bus_io.resp_rdata = q_rdata_q[rd_ptr_q];
  assign bus_io.resp_tag = q_tag_q[rd_ptr_q];

  // Byte merge under the strobes
  always_ff @(posedge clk_i) begin
    if (push && bus_io.req_wen) begin
      for (int i = 0; i < `TCDM_STRB_WIDTH; i++) begin
        if (bus_io.req_be[i]) begin
          mem_q[bus_io.req_row][8*i +: 8] <= bus_io.req_wdata[8*i +: 8];
        end
      end
    end
  end

  // Reads capture the word as it was before this cycle's write
  always_ff @(posedge clk_i) begin
    if (push) begin
      if (bus_io.req_wen) begin
        q_rdata_q[wr_ptr_q] <= '0;
      end else begin
        q_rdata_q[wr_ptr_q] <= mem_q[bus_io.req_row];
      end
      q_tag_q[wr_ptr_q] <= bus_io.req_tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

endmodule

`default_nettype wire

// File: src/tcdm_bank_if.sv
/* Request and response channels between the decoder, one bank
   and the response arbiter */

`timescale 1ns/10ps
`default_nettype none

interface tcdm_bank_if;
  import tcdm_pkg::*;

  // Request channel
  logic req_valid;
  logic req_ready;
  bank_row_t req_row;
  logic req_wen;
  tcdm_data_t req_wdata;
  tcdm_strb_t req_be;
  tcdm_tag_t req_tag;

  // Response channel
  logic resp_valid;
  logic resp_ready;
  tcdm_data_t resp_rdata;
  tcdm_tag_t resp_tag;

  modport decoder (
    output req_valid, req_row, req_wen, req_wdata, req_be, req_tag,
    input req_ready
  );

  modport bank (
    input req_valid, req_row, req_wen, req_wdata, req_be, req_tag, resp_ready,
    output req_ready, resp_valid, resp_rdata, resp_tag
  );

  modport arbiter (
    input resp_valid, resp_rdata, resp_tag,
    output resp_ready
  );

endinterface

`default_nettype wire

// File: src/tcdm_defines.svh
/* Size and width macros of the interleaved TCDM group */

`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// Interleaved banks and words per bank
`define TCDM_NUM_BANKS 4
`define TCDM_BANK_DEPTH 64

// Word and tag widths
`define TCDM_DATA_WIDTH 32
`define TCDM_TAG_WIDTH 4

// Byte address, split as row | bank | byte offset
`define TCDM_ADDR_WIDTH 10

// Derived field widths
`define TCDM_STRB_WIDTH (`TCDM_DATA_WIDTH / 8)
`define TCDM_BYTE_OFF_WIDTH $clog2(`TCDM_STRB_WIDTH)
`define TCDM_BANK_SEL_WIDTH $clog2(`TCDM_NUM_BANKS)
`define TCDM_ROW_WIDTH $clog2(`TCDM_BANK_DEPTH)

`endif

// File: src/tcdm_group.sv
/* TCDM group top: request decoder, interleaved banks and
   response arbiter */

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_group (
  input logic clk_i,
  input logic rst_n_i,
  // Request port
  input logic req_valid_i,
  output logic req_ready_o,
  input tcdm_pkg::tcdm_addr_u req_addr_i,
  input logic req_wen_i,
  input tcdm_pkg::tcdm_data_t req_wdata_i,
  input tcdm_pkg::tcdm_strb_t req_be_i,
  input tcdm_pkg::tcdm_tag_t req_tag_i,
  // Response port
  output logic resp_valid_o,
  input logic resp_ready_i,
  output tcdm_pkg::tcdm_data_t resp_rdata_o,
  output tcdm_pkg::tcdm_tag_t resp_tag_o
);

  tcdm_bank_if bank_bus [`TCDM_NUM_BANKS] ();

  tcdm_req_decoder req_decoder_inst (
    .clk_i (clk_i),
    .rst_n_i (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i (req_addr_i),
    .req_wen_i (req_wen_i),
    .req_wdata_i (req_wdata_i),
    .req_be_i (req_be_i),
    .req_tag_i (req_tag_i),
    .bank_o (bank_bus)
  );

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank
    tcdm_bank bank_inst (
      .clk_i (clk_i),
      .rst_n_i (rst_n_i),
      .bus_io (bank_bus[b])
    );
  end

  tcdm_resp_arbiter resp_arbiter_inst (
    .clk_i (clk_i),
    .rst_n_i (rst_n_i),
    .bank_i (bank_bus),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .resp_tag_o (resp_tag_o)
  );

endmodule

`default_nettype wire

// File: src/tcdm_pkg.sv
/* Shared types of the TCDM group: data, strobe, tag, row, bank select
   and the two views of a byte address */

`default_nettype none

`include "tcdm_defines.svh"

package tcdm_pkg;

  typedef logic [`TCDM_DATA_WIDTH-1:0] tcdm_data_t;
  typedef logic [`TCDM_STRB_WIDTH-1:0] tcdm_strb_t;
  typedef logic [`TCDM_TAG_WIDTH-1:0] tcdm_tag_t;

  typedef logic [`TCDM_ROW_WIDTH-1:0] bank_row_t;
  typedef logic [`TCDM_BANK_SEL_WIDTH-1:0] bank_sel_t;

  // Word interleaving puts the bank select right above the byte offset
  typedef struct packed {
    bank_row_t row;
    bank_sel_t bank;
    logic [`TCDM_BYTE_OFF_WIDTH-1:0] offset;
  } tcdm_addr_fields_t;

  typedef union packed {
    logic [`TCDM_ADDR_WIDTH-1:0] raw;
    tcdm_addr_fields_t fields;
  } tcdm_addr_u;

endpackage

`default_nettype wire

// File: src/tcdm_req_decoder.sv
/* Request cut register and address decode onto the bank channels */

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_req_decoder (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_valid_i,
  output logic req_ready_o,
  input tcdm_pkg::tcdm_addr_u req_addr_i,
  input logic req_wen_i,
  input tcdm_pkg::tcdm_data_t req_wdata_i,
  input tcdm_pkg::tcdm_strb_t req_be_i,
  input tcdm_pkg::tcdm_tag_t req_tag_i,
  tcdm_bank_if.decoder bank_o [`TCDM_NUM_BANKS]
);
  import tcdm_pkg::*;

  logic valid_q;
  tcdm_addr_u addr_q;
  logic wen_q;
  tcdm_data_t wdata_q;
  tcdm_strb_t be_q;
  tcdm_tag_t tag_q;
  logic [`TCDM_NUM_BANKS-1:0] bank_ready;

  // Cut register frees up when the selected bank takes the request
  assign req_ready_o = !valid_q || bank_ready[addr_q.fields.bank];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      addr_q.raw <= req_addr_i.raw;
      wen_q <= req_wen_i;
      wdata_q <= req_wdata_i;
      be_q <= req_be_i;
      tag_q <= req_tag_i;
    end
  end

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank_port
    assign bank_o[b].req_valid = valid_q && (addr_q.fields.bank == bank_sel_t'(b));
    assign bank_o[b].req_row = addr_q.fields.row;
    assign bank_o[b].req_wen = wen_q;
    assign bank_o[b].req_wdata = wdata_q;
    assign bank_o[b].req_be = be_q;
    assign bank_o[b].req_tag = tag_q;
    assign bank_ready[b] = bank_o[b].req_ready;
  end

endmodule

`default_nettype wire

// File: src/tcdm_resp_arbiter.sv
/* Round-robin collection of bank responses into one output register */

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_resp_arbiter (
  input logic clk_i,
  input logic rst_n_i,
  tcdm_bank_if.arbiter bank_i [`TCDM_NUM_BANKS],
  output logic resp_valid_o,
  input logic resp_ready_i,
  output tcdm_pkg::tcdm_data_t resp_rdata_o,
  output tcdm_pkg::tcdm_tag_t resp_tag_o
);
  import tcdm_pkg::*;

  logic [`TCDM_NUM_BANKS-1:0] bank_valid;
  tcdm_data_t bank_rdata [`TCDM_NUM_BANKS];
  tcdm_tag_t bank_tag [`TCDM_NUM_BANKS];

  bank_sel_t last_q;
  bank_sel_t grant_idx;
  logic grant_any;
  logic out_free;
  logic take;

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank_port
    assign bank_valid[b] = bank_i[b].resp_valid;
    assign bank_rdata[b] = bank_i[b].resp_rdata;
    assign bank_tag[b] = bank_i[b].resp_tag;
    assign bank_i[b].resp_ready = take && (grant_idx == bank_sel_t'(b));
  end

  // Search starts at the bank after the last one served
  always_comb begin
    bank_sel_t cand;
    grant_idx = last_q;
    grant_any = 1'b0;
    for (int k = 1; k <= `TCDM_NUM_BANKS; k++) begin
      cand = last_q + bank_sel_t'(k);
      if (!grant_any && bank_valid[cand]) begin
        grant_any = 1'b1;
        grant_idx = cand;
      end
    end
  end

  assign out_free = !resp_valid_o || resp_ready_i;
  assign take = grant_any && out_free;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
      last_q <= '1;
    end else begin
      if (out_free) begin
        resp_valid_o <= grant_any;
      end
      if (take) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      resp_rdata_o <= bank_rdata[grant_idx];
      resp_tag_o <= bank_tag[grant_idx];
    end
  end

endmodule

`default_nettype wire
